//--- verilog/div_pkg.sv
// Divide unit shared definitions
// Operation encoding, execute FSM states and operation width
package div_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Operation encoding
    ////////////////////////////////////////////////////////////////////////////

    // Width of the operation field on the issue port
    localparam int DIV_OP_WIDTH = 2;

    // Bit 0 marks unsigned, bit 1 selects the remainder
    typedef enum logic [DIV_OP_WIDTH-1:0] {
        OP_DIV  = 2'd0,
        OP_DIVU = 2'd1,
        OP_REM  = 2'd2,
        OP_REMU = 2'd3
    } div_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // Execute FSM
    ////////////////////////////////////////////////////////////////////////////

    // Idle waits for start
    // Run does one quotient bit per cycle
    // Done holds for a single cycle while complete is high
    typedef enum logic [1:0] {
        CORE_IDLE = 2'd0,
        CORE_RUN  = 2'd1,
        CORE_DONE = 2'd2
    } core_state_e;

endpackage

//--- verilog/div_ifs.sv
// Divide unit internal interfaces
// Queue head towards result, operands and outcome between decode, core and result
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////////
// Queue head, decode to result
////////////////////////////////////////////////////////////////////////////////
interface div_entry_if import div_pkg::*; #(
    parameter int ID_WIDTH = 3
) ();
    // Head of the input queue
    logic                head_valid;
    div_op_e             head_op;
    logic [ID_WIDTH-1:0] head_id;
    // Same operands as the request before it
    logic                head_reuse;
    // Sign fix-up for the two results
    logic                quotient_negate;
    logic                remainder_negate;
    // Head retires at this edge
    logic                pop;

    modport decode (
        output head_valid, head_op, head_id, head_reuse,
        output quotient_negate, remainder_negate,
        input  pop
    );

    modport result (
        input  head_valid, head_op, head_id, head_reuse,
        input  quotient_negate, remainder_negate,
        output pop
    );
endinterface

////////////////////////////////////////////////////////////////////////////////
// Operands and outcome of the divider
////////////////////////////////////////////////////////////////////////////////
interface div_operand_if #(
    parameter int XLEN = 32
) ();
    logic            start;
    // Unsigned magnitudes of dividend and divisor
    logic [XLEN-1:0] a_mag;
    logic [XLEN-1:0] b_mag;
    // Held until the next start
    logic [XLEN-1:0] quotient;
    logic [XLEN-1:0] remainder;
    logic            complete;
    logic            b_zero;

    modport decode (output start, a_mag, b_mag, input complete);
    modport core (
        input  start, a_mag, b_mag,
        output quotient, remainder, complete, b_zero
    );
    modport result (input quotient, remainder, complete, b_zero);
endinterface

//--- verilog/div_decode.sv
// Divide unit decode stage
// Input queue, operand reuse detection, sign handling and magnitude generation
`timescale 1ns/1ps

module div_decode import div_pkg::*; #(
    parameter int XLEN       = 32,
    parameter int ID_WIDTH   = 3,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                issue,
    input  div_op_e             op,
    input  logic [XLEN-1:0]     rs1,
    input  logic [XLEN-1:0]     rs2,
    input  logic [ID_WIDTH-1:0] issue_id,
    output logic                ready,
    div_entry_if.decode         ent,
    div_operand_if.decode       opnd
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // Queue storage
    div_op_e             q_op    [FIFO_DEPTH];
    logic [XLEN-1:0]     q_rs1   [FIFO_DEPTH];
    logic [XLEN-1:0]     q_rs2   [FIFO_DEPTH];
    logic [ID_WIDTH-1:0] q_id    [FIFO_DEPTH];
    logic                q_reuse [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;

    // Operands of the last accepted request
    logic            last_valid;
    logic [XLEN-1:0] last_rs1;
    logic [XLEN-1:0] last_rs2;
    logic            last_unsigned;
    logic            reuse_in;

    logic            in_progress;
    logic [XLEN-1:0] head_rs1;
    logic [XLEN-1:0] head_rs2;
    logic            signed_op;
    logic            dividend_neg;
    logic            divisor_neg;

    ////////////////////////////////////////////////////////////////////////////
    // Input queue
    ////////////////////////////////////////////////////////////////////////////
    assign ready = (count != CNT_W'(FIFO_DEPTH));
    assign push  = issue & ready;

    // Same operands and signedness as the previous request
    assign reuse_in = last_valid & (rs1 == last_rs1) & (rs2 == last_rs2) &
                      (op[0] == last_unsigned);

    always_ff @(posedge clk) begin
        if (push) begin
            q_op[wr_ptr]    <= op;
            q_rs1[wr_ptr]   <= rs1;
            q_rs2[wr_ptr]   <= rs2;
            q_id[wr_ptr]    <= issue_id;
            q_reuse[wr_ptr] <= reuse_in;
            last_rs1        <= rs1;
            last_rs2        <= rs2;
            last_unsigned   <= op[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            last_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr     <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                last_valid <= 1'b1;
            end
            if (ent.pop)
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // Simultaneous push and pop leaves the count alone
            if (push && !ent.pop)
                count <= count + 1'b1;
            else if (!push && ent.pop)
                count <= count - 1'b1;
        end
    end

    assign ent.head_valid = (count != '0);
    assign ent.head_op    = q_op[rd_ptr];
    assign ent.head_id    = q_id[rd_ptr];
    assign ent.head_reuse = q_reuse[rd_ptr];
    assign head_rs1       = q_rs1[rd_ptr];
    assign head_rs2       = q_rs2[rd_ptr];

    ////////////////////////////////////////////////////////////////////////////
    // Sign handling
    ////////////////////////////////////////////////////////////////////////////
    assign signed_op    = ~ent.head_op[0];
    assign dividend_neg = signed_op & head_rs1[XLEN-1];
    assign divisor_neg  = signed_op & head_rs2[XLEN-1];

    // Zero divisor keeps the all-ones quotient unnegated
    assign ent.quotient_negate  = signed_op & (head_rs1[XLEN-1] ^ head_rs2[XLEN-1]) &
                                  (|head_rs2);
    assign ent.remainder_negate = dividend_neg;

    // Two's complement magnitudes
    assign opnd.a_mag = ({XLEN{dividend_neg}} ^ head_rs1) + XLEN'(dividend_neg);
    assign opnd.b_mag = ({XLEN{divisor_neg}} ^ head_rs2) + XLEN'(divisor_neg);

    ////////////////////////////////////////////////////////////////////////////
    // Divider start
    ////////////////////////////////////////////////////////////////////////////
    assign opnd.start = ent.head_valid & ~ent.head_reuse & ~in_progress;

    // Blocks a second start until the core reports back
    always_ff @(posedge clk) begin
        if (rst)
            in_progress <= 1'b0;
        else if (opnd.start)
            in_progress <= 1'b1;
        else if (opnd.complete)
            in_progress <= 1'b0;
    end

    // Issue side must respect ready
    assert property (@(posedge clk) disable iff (rst) issue |-> ready)
        else $error("div_decode: issue while queue full");

endmodule

//--- verilog/div_core.sv
// Divide unit execute stage
// Radix-2 restoring divider, one quotient bit per cycle
`timescale 1ns/1ps

module div_core import div_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic        clk,
    input  logic        rst,
    div_operand_if.core opnd
);

    localparam int CNT_W = $clog2(XLEN);

    core_state_e state;
    logic [CNT_W-1:0] step;

    // Partial remainder, quotient and divisor registers
    logic [XLEN-1:0] rem_reg;
    logic [XLEN-1:0] quo_reg;
    logic [XLEN-1:0] div_reg;
    logic            b_zero_reg;

    logic [XLEN:0]   shifted;
    logic [XLEN:0]   diff;

    ////////////////////////////////////////////////////////////////////////////
    // Shift and subtract
    ////////////////////////////////////////////////////////////////////////////
    // Next dividend bit enters the partial remainder
    assign shifted = {rem_reg, quo_reg[XLEN-1]};
    assign diff    = shifted - {1'b0, div_reg};

    always_ff @(posedge clk) begin
        if (opnd.start && state == CORE_IDLE) begin
            rem_reg    <= '0;
            quo_reg    <= opnd.a_mag;
            div_reg    <= opnd.b_mag;
            b_zero_reg <= (opnd.b_mag == '0);
        end else if (state == CORE_RUN) begin
            // Restore on borrow, else keep difference
            if (!diff[XLEN]) begin
                rem_reg <= diff[XLEN-1:0];
                quo_reg <= {quo_reg[XLEN-2:0], 1'b1};
            end else begin
                rem_reg <= shifted[XLEN-1:0];
                quo_reg <= {quo_reg[XLEN-2:0], 1'b0};
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CORE_IDLE;
            step  <= '0;
        end else begin
            case (state)
                CORE_IDLE: begin
                    step <= '0;
                    if (opnd.start)
                        state <= CORE_RUN;
                end
                CORE_RUN: begin
                    step <= step + 1'b1;
                    // XLEN steps then report
                    if (step == CNT_W'(XLEN - 1))
                        state <= CORE_DONE;
                end
                CORE_DONE: state <= CORE_IDLE;
                default:   state <= CORE_IDLE;
            endcase
        end
    end

    assign opnd.complete  = (state == CORE_DONE);
    assign opnd.quotient  = quo_reg;
    assign opnd.remainder = rem_reg;
    assign opnd.b_zero    = b_zero_reg;

    // Decode must wait for the previous division
    assert property (@(posedge clk) disable iff (rst) opnd.start |-> state == CORE_IDLE)
        else $error("div_core: start while busy");

    // Fixed latency seen by decode and result
    assert property (@(posedge clk) disable iff (rst) opnd.start |-> ##(XLEN + 1) opnd.complete)
        else $error("div_core: complete latency mismatch");

endmodule

//--- verilog/div_result.sv
// Divide unit result stage
// Sign correction, completion strobe and id-indexed result bank
`timescale 1ns/1ps

module div_result import div_pkg::*; #(
    parameter int XLEN     = 32,
    parameter int ID_WIDTH = 3
) (
    input  logic                clk,
    div_entry_if.result         ent,
    div_operand_if.result       opnd,
    input  logic [ID_WIDTH-1:0] read_id,
    output logic                done,
    output logic [ID_WIDTH-1:0] done_id,
    output logic [XLEN-1:0]     rd
);

    localparam int BANK_DEPTH = 2 ** ID_WIDTH;

    logic            finish;
    logic            sel_rem;
    logic            negate;
    logic [XLEN-1:0] raw_result;
    logic [XLEN-1:0] fixed_result;

    // One entry per instruction id
    logic [XLEN-1:0] bank [BANK_DEPTH];

    ////////////////////////////////////////////////////////////////////////////
    // Completion
    ////////////////////////////////////////////////////////////////////////////
    // Core finished, or head reuses the held quotient and remainder
    assign finish  = opnd.complete | (ent.head_valid & ent.head_reuse);

    assign ent.pop = finish;
    assign done    = finish;
    assign done_id = ent.head_id;

    ////////////////////////////////////////////////////////////////////////////
    // Result select and sign fix-up
    ////////////////////////////////////////////////////////////////////////////
    assign sel_rem      = ent.head_op[1];
    assign raw_result   = sel_rem ? opnd.remainder : opnd.quotient;
    assign negate       = sel_rem ? ent.remainder_negate : ent.quotient_negate;
    assign fixed_result = ({XLEN{negate}} ^ raw_result) + XLEN'(negate);

    always_ff @(posedge clk) begin
        if (finish)
            bank[ent.head_id] <= fixed_result;
    end

    // Writeback read port
    assign rd = bank[read_id];

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////
    // Core only runs for a queued head
    assert property (@(posedge clk) opnd.complete |-> ent.head_valid)
        else $error("div_result: complete without a queued head");

    // Zero divisor gives all ones and no quotient negate
    assert property (@(posedge clk)
        opnd.complete && opnd.b_zero |-> (&opnd.quotient) && !ent.quotient_negate)
        else $error("div_result: divide-by-zero quotient mismatch");

endmodule

//--- verilog/div_unit_top.sv
// Divide unit top level
// Issue queue, iterative divider and result bank behind plain strobe ports
`timescale 1ns/1ps

module div_unit_top import div_pkg::*; #(
    parameter int XLEN       = 32,
    parameter int ID_WIDTH   = 3,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    // Issue side
    input  logic                    issue,
    input  logic [DIV_OP_WIDTH-1:0] op,
    input  logic [XLEN-1:0]         rs1,
    input  logic [XLEN-1:0]         rs2,
    input  logic [ID_WIDTH-1:0]     issue_id,
    output logic                    ready,
    // Writeback side
    output logic                    done,
    output logic [ID_WIDTH-1:0]     done_id,
    input  logic [ID_WIDTH-1:0]     read_id,
    output logic [XLEN-1:0]         rd
);

    div_entry_if   #(.ID_WIDTH(ID_WIDTH)) ent ();
    div_operand_if #(.XLEN(XLEN))         opnd ();

    ////////////////////////////////////////////////////////////////////////////
    // Decode, execute, result
    ////////////////////////////////////////////////////////////////////////////
    div_decode #(
        .XLEN       (XLEN),
        .ID_WIDTH   (ID_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) decode0 (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .op       (div_op_e'(op)),
        .rs1      (rs1),
        .rs2      (rs2),
        .issue_id (issue_id),
        .ready    (ready),
        .ent      (ent.decode),
        .opnd     (opnd.decode)
    );

    div_core #(
        .XLEN (XLEN)
    ) core0 (
        .clk  (clk),
        .rst  (rst),
        .opnd (opnd.core)
    );

    div_result #(
        .XLEN     (XLEN),
        .ID_WIDTH (ID_WIDTH)
    ) result0 (
        .clk     (clk),
        .ent     (ent.result),
        .opnd    (opnd.result),
        .read_id (read_id),
        .done    (done),
        .done_id (done_id),
        .rd      (rd)
    );

endmodule

//--- bench/div_unit_tb.sv
// Divide unit testbench
// Replays golden requests through the issue port and checks done order and the result bank
`timescale 1ns/1ps

module div_unit_tb import div_pkg::*; ();

    localparam int          XLEN        = 32;
    localparam int          ID_WIDTH    = 3;
    localparam int          FIFO_DEPTH  = 4;
    localparam int          TIMEOUT     = 200;
    localparam int          BURST_TEST  = 5;
    localparam logic [15:0] LFSR_SEED   = 16'd35;
    localparam string       GOLDEN_FILE = "bench/div_golden.txt";

    logic                    clk;
    logic                    rst;
    logic                    issue;
    logic [DIV_OP_WIDTH-1:0] op;
    logic [XLEN-1:0]         rs1;
    logic [XLEN-1:0]         rs2;
    logic [ID_WIDTH-1:0]     issue_id;
    logic                    ready;
    logic                    done;
    logic [ID_WIDTH-1:0]     done_id;
    logic [ID_WIDTH-1:0]     read_id;
    logic [XLEN-1:0]         rd;

    // Golden requests in file order
    int                      vec_test [$];
    logic [DIV_OP_WIDTH-1:0] vec_op   [$];
    logic [XLEN-1:0]         vec_rs1  [$];
    logic [XLEN-1:0]         vec_rs2  [$];
    logic [ID_WIDTH-1:0]     vec_id   [$];
    logic [XLEN-1:0]         vec_exp  [$];

    // Expected result per id and ids still in flight
    logic [XLEN-1:0]         exp_by_id [2**ID_WIDTH];
    logic [ID_WIDTH-1:0]     order_q   [$];

    int          checks;
    int          errors;
    int          tests;
    logic        hard_fail;
    logic        stalled;
    logic [15:0] lfsr;

    div_unit_top #(
        .XLEN       (XLEN),
        .ID_WIDTH   (ID_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut0 (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .op       (op),
        .rs1      (rs1),
        .rs2      (rs2),
        .issue_id (issue_id),
        .ready    (ready),
        .done     (done),
        .done_id  (done_id),
        .read_id  (read_id),
        .rd       (rd)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_value(input string what, input logic [XLEN-1:0] actual,
                               input logic [XLEN-1:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // Galois LFSR with taps for a 16-bit maximal sequence
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Two LFSR bits give 0 to 3 idle cycles
    task automatic pick_idle_cycles(output int n);
        logic b0;
        logic b1;
        lfsr = lfsr_step(lfsr);
        b0   = lfsr[0];
        lfsr = lfsr_step(lfsr);
        b1   = lfsr[0];
        n    = int'({b1, b0});
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        logic [31:0] t;
        logic [31:0] o;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] id;
        logic [31:0] e;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the golden file %s", GOLDEN_FILE);
            hard_fail = 1'b1;
        end else begin
            // Comment lines fail the scan and drop out
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%h %h %h %h %h %h", t, o, a, b, id, e);
                if (n == 6) begin
                    vec_test.push_back(int'(t));
                    vec_op.push_back(o[DIV_OP_WIDTH-1:0]);
                    vec_rs1.push_back(a);
                    vec_rs2.push_back(b);
                    vec_id.push_back(id[ID_WIDTH-1:0]);
                    vec_exp.push_back(e);
                end
            end
            $fclose(fd);
            if (vec_test.size() == 0) begin
                $display("The golden file %s holds no requests", GOLDEN_FILE);
                hard_fail = 1'b1;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Issue side
    ////////////////////////////////////////////////////////////////////////////
    task automatic issue_group(input int first, input int last, input logic no_gaps);
        int gap;
        int waited;
        for (int i = first; i < last && !hard_fail; i++) begin
            if (no_gaps)
                gap = 0;
            else
                pick_idle_cycles(gap);
            issue = 1'b0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            // Ready drops only once the queue holds FIFO_DEPTH requests
            if (!ready && !hard_fail)
                check_value("requests in flight at ready low", XLEN'(order_q.size()),
                            XLEN'(FIFO_DEPTH));
            // Hold off while the queue is full
            waited = 0;
            while (!ready && !hard_fail) begin
                stalled = 1'b1;
                @(posedge clk);
                #1;
                waited++;
                if (waited >= TIMEOUT) begin
                    $display("Timeout at %0t ns: ready stayed low for %0d cycles",
                             $time, TIMEOUT);
                    hard_fail = 1'b1;
                end
            end
            if (!hard_fail) begin
                issue    = 1'b1;
                op       = vec_op[i];
                rs1      = vec_rs1[i];
                rs2      = vec_rs2[i];
                issue_id = vec_id[i];
                exp_by_id[vec_id[i]] = vec_exp[i];
                order_q.push_back(vec_id[i]);
                @(posedge clk);
                #1;
            end
        end
        issue = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Writeback side
    ////////////////////////////////////////////////////////////////////////////
    // Done sampled at the falling edge and read back one cycle later
    task automatic collect_results(input int n);
        int                  got;
        int                  idle;
        logic                pend;
        logic [ID_WIDTH-1:0] pend_id;
        logic [XLEN-1:0]     pend_exp;
        logic [ID_WIDTH-1:0] want_id;
        got      = 0;
        idle     = 0;
        pend     = 1'b0;
        pend_id  = '0;
        pend_exp = '0;
        while ((got < n || pend) && !hard_fail) begin
            @(negedge clk);
            if (pend) begin
                check_value("rd", rd, pend_exp);
                pend = 1'b0;
            end
            if (done) begin
                idle = 0;
                if (order_q.size() == 0) begin
                    $display("Done pulse for id %0d at %0t ns with nothing in flight",
                             done_id, $time);
                    hard_fail = 1'b1;
                end else begin
                    want_id = order_q.pop_front();
                    check_value("done_id", XLEN'(done_id), XLEN'(want_id));
                    pend     = 1'b1;
                    pend_id  = done_id;
                    pend_exp = exp_by_id[want_id];
                    got++;
                end
            end else if (got < n) begin
                idle++;
                if (idle >= TIMEOUT) begin
                    $display("Timeout at %0t ns: no done pulse for %0d cycles", $time, TIMEOUT);
                    hard_fail = 1'b1;
                end
            end
            @(posedge clk);
            #1;
            if (pend)
                read_id = pend_id;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int first;
        int last;
        int checks_before;
        int errors_before;
        clk       = 1'b0;
        rst       = 1'b1;
        issue     = 1'b0;
        op        = '0;
        rs1       = '0;
        rs2       = '0;
        issue_id  = '0;
        read_id   = '0;
        checks    = 0;
        errors    = 0;
        tests     = 0;
        hard_fail = 1'b0;
        stalled   = 1'b0;
        lfsr      = LFSR_SEED;
        load_golden();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // One group per test number
        first = 0;
        while (first < vec_test.size() && !hard_fail) begin
            last = first;
            while (last < vec_test.size() && vec_test[last] == vec_test[first])
                last++;
            checks_before = checks;
            errors_before = errors;
            stalled       = 1'b0;
            fork
                issue_group(first, last, vec_test[first] == BURST_TEST);
                collect_results(last - first);
            join
            // Burst must have filled the queue
            if (vec_test[first] == BURST_TEST)
                check_value("ready low during burst", XLEN'(stalled), XLEN'(1'b1));
            $display("Test %0d: %0d requests, %0d checks, %0d errors", vec_test[first],
                     last - first, checks - checks_before, errors - errors_before);
            tests++;
            first = last;
        end

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && !hard_fail && tests > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- compile.f
verilog/div_pkg.sv
verilog/div_ifs.sv
verilog/div_decode.sv
verilog/div_core.sv
verilog/div_result.sv
verilog/div_unit_top.sv
bench/div_unit_tb.sv

//--- Makefile
# Verilator flow for the divide unit testbench
# Any variable can be overridden on the command line, e.g. make TOP=... OBJ_DIR=...

VERILATOR ?= verilator
TOP       ?= div_unit_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
LINTFLAGS ?= -Wall --timing
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Output goes to the console only; the status follows the search for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/div_golden.txt
// test op rs1 rs2 id expected, every column in hex
// op 0 DIV, 1 DIVU, 2 REM, 3 REMU
// Mixed signs, truncating division
1 0 00000014 00000006 0 00000003
1 0 ffffffec 00000006 1 fffffffd
1 0 00000014 fffffffa 2 fffffffd
1 2 00000017 fffffffb 3 00000003
1 2 ffffffe9 00000005 4 fffffffd
1 2 ffffffe9 fffffffb 5 fffffffd
1 1 ffffffec 00000006 6 2aaaaaa7
1 3 ffffffe9 00000010 7 00000009
// Division by zero
2 0 00000007 00000000 0 ffffffff
2 0 fffffff9 00000000 1 ffffffff
2 1 80000000 00000000 2 ffffffff
2 2 fffffff9 00000000 3 fffffff9
2 3 12345678 00000000 4 12345678
2 2 00000005 00000000 5 00000005
// Signed overflow
3 0 80000000 ffffffff 0 80000000
3 2 80000000 ffffffff 1 00000000
3 0 80000000 00000001 2 80000000
3 1 80000000 ffffffff 3 00000000
// Operand reuse after a division
4 0 00000064 00000007 0 0000000e
4 2 00000064 00000007 1 00000002
4 0 00000064 00000007 2 0000000e
4 1 ffffff9c 00000007 3 24924916
4 3 ffffff9c 00000007 4 00000002
4 2 ffffff9c 00000007 5 fffffffe
4 0 ffffff9c 00000007 6 fffffff2
// Back-to-back burst past the queue depth
5 0 000003e8 0000000a 0 00000064
5 1 0000ffff 00000010 1 00000fff
5 2 fffffc18 00000007 2 fffffffa
5 3 deadbeef 00010000 3 0000beef
5 0 7fffffff 00000002 4 3fffffff
5 1 deadbeef 00010000 5 0000dead
5 2 00000009 fffffffd 6 00000000
5 0 fffffc18 fffffff6 7 00000064
